// File: source/capi_pkg.sv
`default_nettype none

package capi_pkg;

  ////////////////////////////////////////
  // bus field widths
  ////////////////////////////////////////

  parameter int ADDRESS_WIDTH = 64;  // effective address
  parameter int SIZE_WIDTH    = 12;  // transfer size in bytes
  parameter int CREDIT_WIDTH  = 8;

  ////////////////////////////////////////
  // bus command codes
  ////////////////////////////////////////

  // only the codes this compute unit raises
  typedef enum logic [12:0] {
    INVALID    = 13'h0000,
    RESTART    = 13'h0001,  // restart after a paged fault
    READ_CL_NA = 13'h0A00,  // read line, no allocate
    READ_CL_S  = 13'h0A50,  // read line, shared
    WRITE_NA   = 13'h0D00   // write, no allocate
  } capi_command_t;

  // credits granted by the bus to this unit
  typedef logic [CREDIT_WIDTH-1:0] credit_count_t;

endpackage

`default_nettype wire

// File: source/cu_pkg.sv
`default_nettype none

package cu_pkg;

  import capi_pkg::*;

  ////////////////////////////////////////
  // command sources
  ////////////////////////////////////////

  parameter int NUM_SOURCES = 4;
  parameter int CU_ID_WIDTH = 8;

  // position in the request vector, 0 wins
  typedef enum logic [1:0] {
    SRC_RESTART = 2'd0,
    SRC_WED     = 2'd1,
    SRC_WRITE   = 2'd2,
    SRC_READ    = 2'd3
  } source_kind_t;

  typedef enum logic [2:0] {
    CMD_INVALID,
    CMD_RESTART,
    CMD_WED,
    CMD_WRITE,
    CMD_READ
  } cmd_type_t;

  // which graph array a command touches
  typedef enum logic [1:0] {
    STRUCT_INVALID,
    IN_DEGREE,
    OUT_DEGREE,
    INV_OUT_DEGREE
  } vertex_struct_t;

  ////////////////////////////////////////
  // command buffer line
  ////////////////////////////////////////

  typedef struct packed {
    logic                     valid;
    capi_command_t            command;
    logic [ADDRESS_WIDTH-1:0] address;
    logic [SIZE_WIDTH-1:0]    size;
    logic [CU_ID_WIDTH-1:0]   cu_id;
    cmd_type_t                cmd_type;
    vertex_struct_t           vertex_struct;
  } command_buffer_line_t;  // 103 bits

endpackage

`default_nettype wire

// File: source/command_buffer_if.sv
`default_nettype none

interface command_buffer_if
  import cu_pkg::*;
();

  // one held line per source, indexed by source_kind_t
  command_buffer_line_t line [NUM_SOURCES];

  logic [NUM_SOURCES-1:0] requests;  // slot full
  logic [NUM_SOURCES-1:0] ready;     // one-hot take pulse

  ////////////////////////////////////////
  // views
  ////////////////////////////////////////

  // slot side
  modport decode (
    output line,
    output requests,
    input  ready
  );

  // selection side
  modport arbiter (
    input  line,
    input  requests,
    output ready
  );

endinterface

`default_nettype wire

// File: source/command_request_decode.sv
`default_nettype none

module command_request_decode
  import capi_pkg::*;
  import cu_pkg::*;
(
  input  logic                     clock,
  input  logic                     rstn,
  input  logic                     req_valid,
  input  source_kind_t             req_kind,
  input  logic [CU_ID_WIDTH-1:0]   req_cu_id,
  input  logic [ADDRESS_WIDTH-1:0] req_address,
  input  logic [SIZE_WIDTH-1:0]    req_size,
  input  vertex_struct_t           req_vertex_struct,
  output logic [NUM_SOURCES-1:0]   slot_busy,
  command_buffer_if.decode         bus
);

  ////////////////////////////////////////
  // kind to command mapping
  ////////////////////////////////////////

  function automatic capi_command_t kind_command(input source_kind_t kind);
    case (kind)
      SRC_RESTART: return RESTART;
      SRC_WED:     return READ_CL_S;  // wed is read shared
      SRC_WRITE:   return WRITE_NA;
      default:     return READ_CL_NA;
    endcase
  endfunction

  function automatic cmd_type_t kind_type(input source_kind_t kind);
    case (kind)
      SRC_RESTART: return CMD_RESTART;
      SRC_WED:     return CMD_WED;
      SRC_WRITE:   return CMD_WRITE;
      default:     return CMD_READ;
    endcase
  endfunction

  command_buffer_line_t   new_line;
  command_buffer_line_t   slot_line [NUM_SOURCES];
  logic [NUM_SOURCES-1:0] slot_full;
  logic [NUM_SOURCES-1:0] kind_onehot;
  logic [NUM_SOURCES-1:0] load;

  always_comb begin
    new_line               = '0;
    new_line.valid         = 1'b1;
    new_line.command       = kind_command(req_kind);
    new_line.address       = req_address;
    new_line.size          = req_size;
    new_line.cu_id         = req_cu_id;
    new_line.cmd_type      = kind_type(req_kind);
    new_line.vertex_struct = req_vertex_struct;
  end

  ////////////////////////////////////////
  // one-deep slots
  ////////////////////////////////////////

  assign kind_onehot = NUM_SOURCES'(1) << req_kind;
  assign load        = {NUM_SOURCES{req_valid}} & kind_onehot & ~slot_full;  // full slot drops

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      slot_full <= '0;
    end else begin
      slot_full <= (slot_full & ~bus.ready) | load;  // empties on its ready
    end
  end

  // held line per source
  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_SOURCES; i++) begin
      if (load[i]) begin
        slot_line[i] <= new_line;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_SOURCES; i++) begin
      bus.line[i]       = slot_line[i];
      bus.line[i].valid = slot_full[i];
    end
  end

  assign bus.requests = slot_full;
  assign slot_busy    = slot_full;

endmodule

`default_nettype wire

// File: source/command_buffer_arbiter.sv
`default_nettype none

module command_buffer_arbiter
  import capi_pkg::*;
  import cu_pkg::*;
#(
  parameter int NUM_REQUESTS = 4
) (
  input  logic                 clock,
  input  logic                 rstn,
  input  logic                 enabled,
  command_buffer_if.arbiter    bus,
  output command_buffer_line_t issued_line
);

  // what goes out when nothing is taken
  localparam command_buffer_line_t IDLE_LINE = '{
    valid:         1'b0,
    command:       INVALID,
    address:       '0,
    size:          '0,
    cu_id:         '0,
    cmd_type:      CMD_INVALID,
    vertex_struct: STRUCT_INVALID
  };

  logic [NUM_REQUESTS-1:0] requests;
  logic [NUM_REQUESTS-1:0] grant;
  command_buffer_line_t    winner_line;

  ////////////////////////////////////////
  // fixed priority, bit 0 first
  ////////////////////////////////////////

  assign requests = bus.requests;

  // isolate the lowest set request bit
  assign grant = requests & (~requests + 1'b1);

  // take only while a credit is there
  assign bus.ready = enabled ? grant : '0;

  // grant is one-hot so at most one line passes
  always_comb begin
    winner_line = IDLE_LINE;
    for (int i = 0; i < NUM_REQUESTS; i++) begin
      if (grant[i]) begin
        winner_line = bus.line[i];
      end
    end
  end

  ////////////////////////////////////////
  // registered issue line
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      issued_line <= IDLE_LINE;
    end else if (enabled && |grant) begin
      issued_line <= winner_line;  // valid the cycle after ready
    end else begin
      issued_line <= IDLE_LINE;    // disabled or idle
    end
  end

endmodule

`default_nettype wire

// File: source/command_credit_tracker.sv
`default_nettype none

module command_credit_tracker
  import capi_pkg::*;
  import cu_pkg::*;
#(
  parameter int NUM_CREDITS = 16
) (
  input  logic                     clock,
  input  logic                     rstn,
  input  command_buffer_line_t     issued_line,
  input  logic                     response_valid,
  output logic                     enabled,
  output credit_count_t            credits,
  output logic                     command_valid,
  output capi_command_t            command_code,
  output logic [ADDRESS_WIDTH-1:0] command_address,
  output logic [SIZE_WIDTH-1:0]    command_size,
  output logic [CU_ID_WIDTH-1:0]   command_cu_id,
  output cmd_type_t                command_cmd_type,
  output vertex_struct_t           command_vertex_struct
);

  credit_count_t credits_left;  // after this cycle's issue

  ////////////////////////////////////////
  // credit count
  ////////////////////////////////////////

  assign credits_left = credits - credit_count_t'(issued_line.valid);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      credits <= credit_count_t'(NUM_CREDITS);
    end else begin
      credits <= credits_left + credit_count_t'(response_valid);  // response refunds one
    end
  end

  // the line in flight already holds a credit
  assign enabled = (credits_left != '0);

  ////////////////////////////////////////
  // bus command outputs
  ////////////////////////////////////////

  assign command_valid         = issued_line.valid;
  assign command_code          = issued_line.command;
  assign command_address       = issued_line.address;
  assign command_size          = issued_line.size;
  assign command_cu_id         = issued_line.cu_id;
  assign command_cmd_type      = issued_line.cmd_type;
  assign command_vertex_struct = issued_line.vertex_struct;

endmodule

`default_nettype wire

// File: source/command_issue_top.sv
`default_nettype none

module command_issue_top
  import capi_pkg::*;
  import cu_pkg::*;
#(
  parameter int NUM_CREDITS = 16
) (
  input  logic                     clock,
  input  logic                     rstn,
  // request side
  input  logic                     req_valid,
  input  source_kind_t             req_kind,
  input  logic [CU_ID_WIDTH-1:0]   req_cu_id,
  input  logic [ADDRESS_WIDTH-1:0] req_address,
  input  logic [SIZE_WIDTH-1:0]    req_size,
  input  vertex_struct_t           req_vertex_struct,
  input  logic                     response_valid,  // one credit back
  output logic [NUM_SOURCES-1:0]   slot_busy,
  // bus command side
  output logic                     command_valid,
  output capi_command_t            command_code,
  output logic [ADDRESS_WIDTH-1:0] command_address,
  output logic [SIZE_WIDTH-1:0]    command_size,
  output logic [CU_ID_WIDTH-1:0]   command_cu_id,
  output cmd_type_t                command_cmd_type,
  output vertex_struct_t           command_vertex_struct,
  output credit_count_t            credits
);

  command_buffer_if     cmd_bus ();
  command_buffer_line_t issued_line;
  logic                 enabled;

  command_request_decode command_request_decode_i (
    .clock             (clock),
    .rstn              (rstn),
    .req_valid         (req_valid),
    .req_kind          (req_kind),
    .req_cu_id         (req_cu_id),
    .req_address       (req_address),
    .req_size          (req_size),
    .req_vertex_struct (req_vertex_struct),
    .slot_busy         (slot_busy),
    .bus               (cmd_bus.decode)
  );

  command_buffer_arbiter #(
    .NUM_REQUESTS (NUM_SOURCES)
  ) command_buffer_arbiter_i (
    .clock       (clock),
    .rstn        (rstn),
    .enabled     (enabled),
    .bus         (cmd_bus.arbiter),
    .issued_line (issued_line)
  );

  command_credit_tracker #(
    .NUM_CREDITS (NUM_CREDITS)
  ) command_credit_tracker_i (
    .clock                 (clock),
    .rstn                  (rstn),
    .issued_line           (issued_line),
    .response_valid        (response_valid),
    .enabled               (enabled),
    .credits               (credits),
    .command_valid         (command_valid),
    .command_code          (command_code),
    .command_address       (command_address),
    .command_size          (command_size),
    .command_cu_id         (command_cu_id),
    .command_cmd_type      (command_cmd_type),
    .command_vertex_struct (command_vertex_struct)
  );

endmodule

`default_nettype wire

// File: testbench/command_issue_table.svh
localparam int NUM_ROWS = 12;

// one row per step, applied in order
//   strobe count and kinds in load order
//   response pulses sent after the strobes
//   issue count and kinds in expected bus order
//   credits once the row has settled
localparam table_row_t TABLE_ROWS [NUM_ROWS] = '{
  // one request of each kind takes credits 4 down to 0
  '{3'd1, {SRC_RESTART, 6'd0}, 3'd0, 3'd1, {SRC_RESTART, 6'd0}, 8'd3},
  '{3'd1, {SRC_WED, 6'd0},     3'd0, 3'd1, {SRC_WED, 6'd0},     8'd2},
  '{3'd1, {SRC_WRITE, 6'd0},   3'd0, 3'd1, {SRC_WRITE, 6'd0},   8'd1},
  '{3'd1, {SRC_READ, 6'd0},    3'd0, 3'd1, {SRC_READ, 6'd0},    8'd0},

  // no credits left so all four slots fill in reverse order
  '{3'd4, {SRC_READ, SRC_WRITE, SRC_WED, SRC_RESTART}, 3'd0, 3'd0, 8'd0, 8'd0},

  // each response frees one waiting slot in priority order
  // the repeat strobe hits a full slot and is dropped
  '{3'd1, {SRC_READ, 6'd0}, 3'd1, 3'd1, {SRC_RESTART, 6'd0},        8'd0},
  '{3'd1, {SRC_WED, 6'd0},  3'd2, 3'd2, {SRC_WED, SRC_WRITE, 4'd0}, 8'd0},
  '{3'd0, 8'd0,             3'd4, 3'd1, {SRC_READ, 6'd0},           8'd3},

  // back to back strobes of one kind
  '{3'd2, {SRC_WRITE, SRC_WRITE, 4'd0}, 3'd1, 3'd1, {SRC_WRITE, 6'd0}, 8'd3},

  // with credits to spare the load order decides
  '{3'd2, {SRC_READ, SRC_RESTART, 4'd0}, 3'd0,
    3'd2, {SRC_READ, SRC_RESTART, 4'd0}, 8'd1},

  // last credit goes to wed and the rest wait for responses
  '{3'd4, {SRC_WED, SRC_WRITE, SRC_RESTART, SRC_READ}, 3'd3,
    3'd4, {SRC_WED, SRC_RESTART, SRC_WRITE, SRC_READ}, 8'd0},

  // every credit comes back
  '{3'd0, 8'd0, 3'd4, 3'd0, 8'd0, 8'd4}
};

// File: testbench/command_issue_tb.sv
`default_nettype none

module command_issue_tb
  import capi_pkg::*;
  import cu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CREDITS    = 4;
  localparam int TIMEOUT_CYCLES = 50;
  localparam int SETTLE_CYCLES  = 4;  // quiet time before the end of row checks

  // decode mapping per source kind
  localparam capi_command_t KIND_COMMAND [NUM_SOURCES] = '{RESTART, READ_CL_S, WRITE_NA,
                                                           READ_CL_NA};
  localparam cmd_type_t     KIND_TYPE [NUM_SOURCES]    = '{CMD_RESTART, CMD_WED, CMD_WRITE,
                                                           CMD_READ};

  typedef struct packed {
    logic [2:0]    num_strobes;
    logic [7:0]    strobe_kinds;  // first kind in the top bits
    logic [2:0]    num_responses;
    logic [2:0]    num_issues;
    logic [7:0]    issue_kinds;
    credit_count_t credits;
  } table_row_t;

  `include "command_issue_table.svh"

  logic                     clock;
  logic                     rstn;
  logic                     req_valid;
  source_kind_t             req_kind;
  logic [CU_ID_WIDTH-1:0]   req_cu_id;
  logic [ADDRESS_WIDTH-1:0] req_address;
  logic [SIZE_WIDTH-1:0]    req_size;
  vertex_struct_t           req_vertex_struct;
  logic                     response_valid;
  logic [NUM_SOURCES-1:0]   slot_busy;
  logic                     command_valid;
  capi_command_t            command_code;
  logic [ADDRESS_WIDTH-1:0] command_address;
  logic [SIZE_WIDTH-1:0]    command_size;
  logic [CU_ID_WIDTH-1:0]   command_cu_id;
  cmd_type_t                command_cmd_type;
  vertex_struct_t           command_vertex_struct;
  credit_count_t            credits;

  logic [31:0]            lfsr_state;
  command_buffer_line_t   expected_slot [NUM_SOURCES];  // scoreboard per kind
  logic [NUM_SOURCES-1:0] expected_full;
  command_buffer_line_t   observed [$];

  command_issue_top #(
    .NUM_CREDITS (NUM_CREDITS)
  ) command_issue_top_i (.*);

  always #5 clock = ~clock;

  // bus side sampled away from the drive edge
  always @(negedge clock) begin
    if (rstn && command_valid) begin
      observed.push_back({command_valid, command_code, command_address, command_size,
                          command_cu_id, command_cmd_type, command_vertex_struct});
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [63:0] random_bits(input int width);
    logic [63:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < width; i++) begin
      feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      value      = {value[62:0], feedback};
    end
    return value;
  endfunction

  task automatic stop_run(input string text);
    $display("%s", text);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_line(input command_buffer_line_t expected,
                            input command_buffer_line_t actual, input string what);
    if (actual !== expected) begin
      stop_run($sformatf("Mismatch at %0d ns: %s gave line %h, expected %h",
                         $time, what, actual, expected));
    end
  endtask

  task automatic check_credits(input credit_count_t expected, input credit_count_t actual,
                               input string what);
    if (actual !== expected) begin
      stop_run($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d",
                         $time, what, actual, expected));
    end
  endtask

  task automatic check_busy(input logic [NUM_SOURCES-1:0] expected,
                            input logic [NUM_SOURCES-1:0] actual, input string what);
    if (actual !== expected) begin
      stop_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b",
                         $time, what, actual, expected));
    end
  endtask

  task automatic send_strobe(input source_kind_t kind);
    command_buffer_line_t line;
    logic [63:0]          bits;
    line.valid         = 1'b1;
    line.command       = KIND_COMMAND[kind];
    line.address       = random_bits(ADDRESS_WIDTH);
    bits               = random_bits(SIZE_WIDTH);
    line.size          = bits[SIZE_WIDTH-1:0];
    bits               = random_bits(CU_ID_WIDTH);
    line.cu_id         = bits[CU_ID_WIDTH-1:0];
    line.cmd_type      = KIND_TYPE[kind];
    bits               = random_bits(2);
    line.vertex_struct = vertex_struct_t'(bits[1:0]);
    @(posedge clock);
    #1;
    req_valid         = 1'b1;
    req_kind          = kind;
    req_cu_id         = line.cu_id;
    req_address       = line.address;
    req_size          = line.size;
    req_vertex_struct = line.vertex_struct;
    if (!expected_full[kind]) begin  // a full slot keeps its first line
      expected_slot[kind] = line;
      expected_full[kind] = 1'b1;
    end
  endtask

  task automatic wait_issue(output command_buffer_line_t line);
    int cycles;
    cycles = 0;
    while (observed.size() == 0) begin
      if (cycles == TIMEOUT_CYCLES) begin
        stop_run("Timed out after 50 cycles waiting for command_valid");
      end else begin
        @(posedge clock);
        cycles++;
      end
    end
    line = observed.pop_front();
  endtask

  task automatic apply_row(input table_row_t row, input int index);
    command_buffer_line_t seen;
    source_kind_t         kind;
    for (int i = 0; i < int'(row.num_strobes); i++) begin
      send_strobe(source_kind_t'(row.strobe_kinds[7-2*i -: 2]));
    end
    @(posedge clock);
    #1;
    req_valid = 1'b0;
    for (int i = 0; i < int'(row.num_responses); i++) begin
      @(posedge clock);
      #1;
      response_valid = 1'b1;  // one credit back per cycle high
    end
    @(posedge clock);
    #1;
    response_valid = 1'b0;
    for (int i = 0; i < int'(row.num_issues); i++) begin
      kind = source_kind_t'(row.issue_kinds[7-2*i -: 2]);
      wait_issue(seen);
      check_line(expected_slot[kind], seen, $sformatf("row %0d issue %0d", index, i));
      expected_full[kind] = 1'b0;
    end
    repeat (SETTLE_CYCLES) @(posedge clock);
    #2;
    if (observed.size() != 0) begin
      stop_run($sformatf("Row %0d issued more commands than expected", index));
    end
    check_credits(row.credits, credits, $sformatf("row %0d credits", index));
    check_busy(expected_full, slot_busy, $sformatf("row %0d slot_busy", index));
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    clock             = 1'b0;
    rstn              = 1'b0;
    lfsr_state        = 32'hdaaca675;
    expected_full     = '0;
    req_valid         = 1'b0;
    req_kind          = SRC_RESTART;
    req_cu_id         = '0;
    req_address       = '0;
    req_size          = '0;
    req_vertex_struct = STRUCT_INVALID;
    response_valid    = 1'b0;
    repeat (8) @(posedge clock);
    #1;
    rstn = 1'b1;
    @(posedge clock);
    #2;
    check_line('0, {command_valid, command_code, command_address, command_size,
                    command_cu_id, command_cmd_type, command_vertex_struct}, "after reset");
    check_credits(credit_count_t'(NUM_CREDITS), credits, "credits after reset");
    check_busy('0, slot_busy, "slot_busy after reset");
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(TABLE_ROWS[r], r);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+testbench
source/capi_pkg.sv
source/cu_pkg.sv
source/command_buffer_if.sv
source/command_request_decode.sv
source/command_buffer_arbiter.sv
source/command_credit_tracker.sv
source/command_issue_top.sv
testbench/command_issue_tb.sv

// File: Makefile
SOURCES = vlog.f $(wildcard source/*.sv) $(wildcard testbench/*.sv testbench/*.svh)

obj_dir/Vcommand_issue_tb: $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module command_issue_tb -f vlog.f

run: obj_dir/Vcommand_issue_tb
	-./obj_dir/Vcommand_issue_tb > sim.log 2>&1
	cat sim.log
	! grep -q "Test failed" sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
